// File: project.f
rtl/eth_rx_pkg.sv
rtl/gmii_rx_frontend.sv
rtl/rx_crc_check.sv
rtl/rx_buffer_writer.sv
rtl/eth_rx_top.sv
testbench/rx_checker.sv
testbench/tb_eth_rx.sv

// File: rtl/eth_rx_pkg.sv
package eth_rx_pkg;

    localparam logic [7:0]  PREAMBLE_BYTE   = 8'h55;
    localparam logic [7:0]  SFD_BYTE        = 8'hD5;

    localparam logic [31:0] CRC_INIT        = 32'hFFFF_FFFF;
    localparam logic [31:0] CRC_POLY        = 32'hEDB8_8320;  // 802.3 poly, bit reversed
    localparam logic [31:0] CRC_RESIDUE     = 32'hDEBB_20E3;  // register after data + fcs

    localparam int unsigned FCS_BYTES       = 4;
    localparam int unsigned MIN_FRAME_BYTES = 64;             // incl. fcs
    localparam int unsigned MAX_FRAME_BYTES = 1518;           // incl. fcs
    localparam int unsigned ADDR_W          = 16;

    typedef enum logic [1:0] {
        IDLE,
        PREAMBLE,
        PAYLOAD,
        DROP
    } frontend_state_e;

    typedef enum logic [2:0] {
        WAIT_ARM,
        ARMED,
        RECEIVE,
        SKIP,
        DONE
    } writer_state_e;

    typedef enum logic [2:0] {
        FRAME_OK       = 3'd0,
        FRAME_CRC_BAD  = 3'd1,
        FRAME_RX_ERR   = 3'd2,
        FRAME_RUNT     = 3'd3,
        FRAME_OVERSIZE = 3'd4
    } frame_status_e;

endpackage

// File: rtl/eth_rx_top.sv
`timescale 1ns/100ps

module eth_rx_top (
    input  logic                          gmii_rxc,
    input  logic                          rst,
    input  logic [7:0]                    gmii_rxd_i,
    input  logic                          gmii_rx_dv_i,
    input  logic                          gmii_rx_er_i,
    input  logic [eth_rx_pkg::ADDR_W-1:0] rx_addr_i,
    input  logic                          rx_ready_i,
    output logic [7:0]                    rx_data_o,
    output logic [eth_rx_pkg::ADDR_W-1:0] rx_addr_o,
    output logic                          rx_valid_o,
    output logic [eth_rx_pkg::ADDR_W-1:0] rx_len_o,
    output eth_rx_pkg::frame_status_e     rx_status_o,
    output logic                          rx_done_o,
    output logic [15:0]                   rx_drop_cnt_o
);
    import eth_rx_pkg::*;

    logic [7:0]        fr_data;
    logic              fr_valid;
    logic              fr_last;
    logic              fr_err;

    logic [7:0]        pl_data;       // fcs already removed
    logic              pl_valid;
    logic              pl_last;
    logic [ADDR_W-1:0] pl_len;
    frame_status_e     pl_status;

    gmii_rx_frontend u_frontend (
        .gmii_rxc     (gmii_rxc),
        .rst          (rst),
        .gmii_rxd_i   (gmii_rxd_i),
        .gmii_rx_dv_i (gmii_rx_dv_i),
        .gmii_rx_er_i (gmii_rx_er_i),
        .fr_data_o    (fr_data),
        .fr_valid_o   (fr_valid),
        .fr_last_o    (fr_last),
        .fr_err_o     (fr_err)
    );

    rx_crc_check u_crc_check (
        .gmii_rxc    (gmii_rxc),
        .rst         (rst),
        .fr_data_i   (fr_data),
        .fr_valid_i  (fr_valid),
        .fr_last_i   (fr_last),
        .fr_err_i    (fr_err),
        .pl_data_o   (pl_data),
        .pl_valid_o  (pl_valid),
        .pl_last_o   (pl_last),
        .pl_len_o    (pl_len),
        .pl_status_o (pl_status)
    );

    rx_buffer_writer u_writer (
        .gmii_rxc      (gmii_rxc),
        .rst           (rst),
        .pl_data_i     (pl_data),
        .pl_valid_i    (pl_valid),
        .pl_last_i     (pl_last),
        .pl_len_i      (pl_len),
        .pl_status_i   (pl_status),
        .rx_addr_i     (rx_addr_i),
        .rx_ready_i    (rx_ready_i),
        .rx_data_o     (rx_data_o),
        .rx_addr_o     (rx_addr_o),
        .rx_valid_o    (rx_valid_o),
        .rx_len_o      (rx_len_o),
        .rx_status_o   (rx_status_o),
        .rx_done_o     (rx_done_o),
        .rx_drop_cnt_o (rx_drop_cnt_o)
    );

endmodule

// File: rtl/gmii_rx_frontend.sv
`timescale 1ns/100ps

module gmii_rx_frontend (
    input  logic       gmii_rxc,
    input  logic       rst,
    input  logic [7:0] gmii_rxd_i,
    input  logic       gmii_rx_dv_i,
    input  logic       gmii_rx_er_i,
    output logic [7:0] fr_data_o,
    output logic       fr_valid_o,
    output logic       fr_last_o,
    output logic       fr_err_o
);
    import eth_rx_pkg::*;

    frontend_state_e state;
    logic [7:0]      hold_data;    // byte kept back to find the last one
    logic            hold_valid;
    logic            err_acc;      // rx_er seen since preamble

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            state      <= IDLE;
            hold_valid <= 1'b0;
            err_acc    <= 1'b0;
            fr_valid_o <= 1'b0;
            fr_last_o  <= 1'b0;
        end else begin
            fr_valid_o <= 1'b0;
            fr_last_o  <= 1'b0;
            case (state)
                IDLE: begin
                    hold_valid <= 1'b0;
                    err_acc    <= gmii_rx_dv_i & gmii_rx_er_i;
                    if (gmii_rx_dv_i) begin
                        if (gmii_rxd_i == PREAMBLE_BYTE) begin
                            state <= PREAMBLE;
                        end else if (gmii_rxd_i == SFD_BYTE) begin
                            state <= PAYLOAD;    // no preamble at all
                        end else begin
                            state <= DROP;
                        end
                    end
                end
                PREAMBLE: begin
                    hold_valid <= 1'b0;
                    err_acc    <= err_acc | gmii_rx_er_i;
                    if (!gmii_rx_dv_i) begin
                        state <= IDLE;
                    end else if (gmii_rxd_i == SFD_BYTE) begin
                        state <= PAYLOAD;
                    end else if (gmii_rxd_i != PREAMBLE_BYTE) begin
                        state <= DROP;
                    end
                end
                PAYLOAD: begin
                    if (gmii_rx_dv_i) begin
                        hold_valid <= 1'b1;
                        err_acc    <= err_acc | gmii_rx_er_i;
                        fr_valid_o <= hold_valid;
                    end else begin
                        state      <= IDLE;
                        hold_valid <= 1'b0;
                        fr_valid_o <= hold_valid;
                        fr_last_o  <= hold_valid;  // dv fell, held byte is the last
                    end
                end
                DROP: begin
                    hold_valid <= 1'b0;
                    err_acc    <= 1'b0;
                    if (!gmii_rx_dv_i) begin
                        state <= IDLE;
                    end
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rxc) begin
        if (state == PAYLOAD && gmii_rx_dv_i) begin
            hold_data <= gmii_rxd_i;
        end
        if (state == PAYLOAD && hold_valid) begin
            fr_data_o <= hold_data;
            fr_err_o  <= err_acc;          // only looked at with fr_last_o
        end
    end

endmodule

// File: rtl/rx_buffer_writer.sv
`timescale 1ns/100ps

module rx_buffer_writer (
    input  logic                          gmii_rxc,
    input  logic                          rst,
    input  logic [7:0]                    pl_data_i,
    input  logic                          pl_valid_i,
    input  logic                          pl_last_i,
    input  logic [eth_rx_pkg::ADDR_W-1:0] pl_len_i,
    input  eth_rx_pkg::frame_status_e     pl_status_i,
    input  logic [eth_rx_pkg::ADDR_W-1:0] rx_addr_i,
    input  logic                          rx_ready_i,
    output logic [7:0]                    rx_data_o,
    output logic [eth_rx_pkg::ADDR_W-1:0] rx_addr_o,
    output logic                          rx_valid_o,
    output logic [eth_rx_pkg::ADDR_W-1:0] rx_len_o,
    output eth_rx_pkg::frame_status_e     rx_status_o,
    output logic                          rx_done_o,
    output logic [15:0]                   rx_drop_cnt_o
);
    import eth_rx_pkg::*;

    writer_state_e     state;
    logic [ADDR_W-1:0] wr_addr;       // next ram address
    logic              frame_start;   // only meaningful outside a frame
    logic              write_en;

    assign frame_start = pl_valid_i | pl_last_i;
    assign write_en    = pl_valid_i && (state == ARMED || state == RECEIVE);

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            state         <= WAIT_ARM;
            rx_valid_o    <= 1'b0;
            rx_done_o     <= 1'b0;
            rx_len_o      <= '0;
            rx_status_o   <= FRAME_OK;
            rx_drop_cnt_o <= '0;
        end else begin
            rx_valid_o <= write_en;
            case (state)
                WAIT_ARM: begin
                    if (frame_start) begin
                        if (pl_last_i) begin
                            rx_drop_cnt_o <= rx_drop_cnt_o + 1'b1;
                        end else begin
                            state <= SKIP;
                        end
                    end else if (!rx_done_o && !rx_ready_i) begin
                        state <= ARMED;
                    end
                end
                ARMED, RECEIVE: begin
                    if (pl_valid_i) begin
                        state <= RECEIVE;
                    end
                    if (pl_last_i) begin
                        rx_len_o    <= pl_len_i;
                        rx_status_o <= pl_status_i;
                        state       <= DONE;
                    end
                end
                SKIP: begin
                    if (rx_done_o && rx_ready_i) begin
                        rx_done_o <= 1'b0;         // host ack still honoured
                    end
                    if (pl_last_i) begin
                        rx_drop_cnt_o <= rx_drop_cnt_o + 1'b1;
                        state         <= (rx_done_o && !rx_ready_i) ? DONE : WAIT_ARM;
                    end
                end
                DONE: begin
                    if (!rx_done_o) begin
                        rx_done_o <= 1'b1;         // one cycle after last write
                    end else if (rx_ready_i) begin
                        rx_done_o <= 1'b0;
                        state     <= WAIT_ARM;
                    end
                    if (frame_start) begin
                        if (pl_last_i) begin
                            rx_drop_cnt_o <= rx_drop_cnt_o + 1'b1;
                        end else begin
                            state <= SKIP;
                        end
                    end
                end
                default: begin
                    state <= WAIT_ARM;
                end
            endcase
        end
    end

    always_ff @(posedge gmii_rxc) begin
        if (state == WAIT_ARM) begin
            wr_addr <= rx_addr_i;          // base as seen when arming
        end else if (write_en) begin
            wr_addr <= wr_addr + 1'b1;
        end
        if (write_en) begin
            rx_data_o <= pl_data_i;
            rx_addr_o <= wr_addr;
        end
    end

endmodule

// File: rtl/rx_crc_check.sv
`timescale 1ns/100ps

module rx_crc_check (
    input  logic                          gmii_rxc,
    input  logic                          rst,
    input  logic [7:0]                    fr_data_i,
    input  logic                          fr_valid_i,
    input  logic                          fr_last_i,
    input  logic                          fr_err_i,
    output logic [7:0]                    pl_data_o,
    output logic                          pl_valid_o,
    output logic                          pl_last_o,
    output logic [eth_rx_pkg::ADDR_W-1:0] pl_len_o,
    output eth_rx_pkg::frame_status_e     pl_status_o
);
    import eth_rx_pkg::*;

    logic [7:0]        dly [FCS_BYTES];   // newest byte in dly[0]
    logic [ADDR_W-1:0] byte_cnt;          // bytes seen before the current one
    logic [ADDR_W-1:0] cnt_inc;
    logic              pop;
    logic [31:0]       crc;
    logic [31:0]       crc_next;
    logic [7:0]        pend_data;         // last payload byte, sent with status
    logic              pend_valid;
    logic              end_seen;
    logic [ADDR_W-1:0] frame_len;
    logic              frame_err;
    logic [ADDR_W-1:0] len_calc;
    frame_status_e     status_calc;

    function automatic logic [31:0] crc32_byte(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        r = c ^ {24'd0, d};
        for (int i = 0; i < 8; i++) begin
            r = r[0] ? ((r >> 1) ^ CRC_POLY) : (r >> 1);
        end
        return r;
    endfunction

    assign cnt_inc  = (byte_cnt > MAX_FRAME_BYTES) ? byte_cnt : byte_cnt + 1'b1;  // saturate
    assign pop      = (byte_cnt >= FCS_BYTES) && (byte_cnt < MAX_FRAME_BYTES);
    assign crc_next = crc32_byte((byte_cnt == '0) ? CRC_INIT : crc, fr_data_i);

    always_comb begin
        if (frame_len > MAX_FRAME_BYTES) begin
            len_calc = ADDR_W'(MAX_FRAME_BYTES - FCS_BYTES);
        end else if (frame_len >= FCS_BYTES) begin
            len_calc = frame_len - ADDR_W'(FCS_BYTES);
        end else begin
            len_calc = '0;
        end

        if (frame_err) begin
            status_calc = FRAME_RX_ERR;
        end else if (frame_len > MAX_FRAME_BYTES) begin
            status_calc = FRAME_OVERSIZE;
        end else if (frame_len < MIN_FRAME_BYTES) begin
            status_calc = FRAME_RUNT;
        end else if (crc != CRC_RESIDUE) begin
            status_calc = FRAME_CRC_BAD;
        end else begin
            status_calc = FRAME_OK;
        end
    end

    always_ff @(posedge gmii_rxc) begin
        if (rst) begin
            byte_cnt    <= '0;
            end_seen    <= 1'b0;
            pend_valid  <= 1'b0;
            pl_valid_o  <= 1'b0;
            pl_last_o   <= 1'b0;
            pl_len_o    <= '0;
            pl_status_o <= FRAME_OK;
        end else begin
            pl_valid_o <= 1'b0;
            pl_last_o  <= 1'b0;
            if (fr_valid_i) begin
                if (fr_last_i) begin
                    byte_cnt   <= '0;
                    end_seen   <= 1'b1;
                    pend_valid <= pop;
                end else begin
                    byte_cnt   <= cnt_inc;
                    pl_valid_o <= pop;
                end
            end
            if (end_seen) begin     // crc now covers the whole frame
                end_seen    <= 1'b0;
                pl_valid_o  <= pend_valid;
                pl_last_o   <= 1'b1;
                pl_len_o    <= len_calc;
                pl_status_o <= status_calc;
            end
        end
    end

    always_ff @(posedge gmii_rxc) begin
        if (fr_valid_i) begin
            crc    <= crc_next;
            dly[0] <= fr_data_i;
            for (int i = 1; i < FCS_BYTES; i++) begin
                dly[i] <= dly[i-1];
            end
            if (fr_last_i) begin
                frame_len <= cnt_inc;
                frame_err <= fr_err_i;
                pend_data <= dly[FCS_BYTES-1];
            end
        end
        if (end_seen) begin
            pl_data_o <= pend_data;
        end else if (fr_valid_i && !fr_last_i && pop) begin
            pl_data_o <= dly[FCS_BYTES-1];
        end
    end

endmodule

// File: testbench/eth_rx_testdata.txt
# name base(hex) ack len(incl fcs) seed(hex) corrupt_idx er_idx bad_pre done exp_len status drops
# status 0 ok 1 crc_bad 2 rx_err 3 runt 4 oversize, index -1 means none
good_64            0100 0 64   11 -1 -1 0 1 60   0 0
good_200           0400 1 200  22 -1 -1 0 1 196  0 0
crc_bad            0800 1 100  33 10 -1 0 1 96   1 0
rx_err             0c00 1 80   44 -1 20 0 1 76   2 0
runt_40            1000 1 40   55 -1 -1 0 1 36   3 0
oversize_1600      2000 1 1600 66 -1 -1 0 1 1514 4 0
bad_preamble       3000 1 64   77 -1 -1 1 0 0    0 0
good_after_bad_pre 3000 1 72   88 -1 -1 0 1 68   0 0
drop_no_ack        3000 0 64   99 -1 -1 0 0 0    0 1
good_new_base      5000 1 128  aa -1 -1 0 1 124  0 1
good_last          6000 1 64   bb -1 -1 0 1 60   0 1

// File: testbench/rx_checker.sv
`timescale 1ns/100ps

module rx_checker (
    input  logic        gmii_rxc,
    input  logic        rst,
    input  logic [7:0]  rx_data_i,
    input  logic [15:0] rx_addr_i,
    input  logic        rx_valid_i,
    input  logic [15:0] rx_len_i,
    input  logic [2:0]  rx_status_i,
    input  logic        rx_done_i,
    input  logic [15:0] rx_drop_cnt_i,
    input  int          test_idx_i,
    input  logic        gap_done_i,
    output int          pass_cnt_o,
    output int          fail_cnt_o
);
    string      names [64];
    int         rec [64][11];
    logic [7:0] mem [int];      // ram model keyed by address
    int         wr_cnt;
    logic       done_seen;
    logic       test_bad;
    logic       rst_q;
    logic       done_q;

    function automatic logic [7:0] payload_byte(input int s, input int i);
        return 8'(s * 3 + i * 13 + (i >> 5));
    endfunction

    task automatic value_error(input string test, input string what, input int exp, input int act);
        $display("[ERROR] %s: %s expected 0x%0h actual 0x%0h", test, what, exp, act);
        test_bad = 1'b1;
    endtask

    task automatic close_test(input string test);
        if (test_bad) begin
            $display("test %s: FAIL", test);
            fail_cnt_o++;
        end else begin
            $display("test %s: pass", test);
            pass_cnt_o++;
        end
        test_bad  = 1'b0;
        done_seen = 1'b0;
        wr_cnt    = 0;
        mem.delete();
    endtask

    task automatic check_done(input int t);
        int         a;
        logic [7:0] exp_b;
        if (rec[t][7] == 0) begin
            $display("%s: done was raised although the frame must be dropped", names[t]);
            test_bad = 1'b1;
            return;
        end
        done_seen = 1'b1;
        if (rx_len_i != rec[t][8]) value_error(names[t], "length", rec[t][8], rx_len_i);
        if (rx_status_i != rec[t][9]) value_error(names[t], "status", rec[t][9], rx_status_i);
        if (wr_cnt != rec[t][8]) value_error(names[t], "write count", rec[t][8], wr_cnt);
        for (int i = 0; i < rec[t][8]; i++) begin
            a     = (rec[t][0] + i) & 16'hFFFF;
            exp_b = payload_byte(rec[t][3], i) ^ ((i == rec[t][4]) ? 8'hFF : 8'h00);
            if (!mem.exists(a)) begin
                $display("%s: nothing was written at address 0x%0h", names[t], a);
                test_bad = 1'b1;
                break;
            end else if (mem[a] !== exp_b) begin
                value_error(names[t], $sformatf("byte at 0x%0h", a), exp_b, mem[a]);
                break;
            end
        end
    endtask

    task automatic finish_test(input int t);
        if (rec[t][7] != 0 && !done_seen) begin
            $display("%s: done never rose for this frame", names[t]);
            test_bad = 1'b1;
        end
        if (rec[t][7] == 0 && wr_cnt != 0) value_error(names[t], "write count", 0, wr_cnt);
        if (rx_drop_cnt_i != rec[t][10]) begin
            value_error(names[t], "drop count", rec[t][10], rx_drop_cnt_i);
        end
        close_test(names[t]);
    endtask

    initial begin
        int    fd;
        int    n;
        string line;
        pass_cnt_o = 0;
        fail_cnt_o = 0;
        wr_cnt     = 0;
        done_seen  = 1'b0;
        test_bad   = 1'b0;
        rst_q      = 1'b1;
        done_q     = 1'b0;
        n          = 0;
        fd = $fopen("testbench/eth_rx_testdata.txt", "r");
        if (fd == 0) begin
            $display("checker could not open the test data file");
            fail_cnt_o = 1;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    void'($sscanf(line, "%s %h %d %d %h %d %d %d %d %d %d %d",
                        names[n], rec[n][0], rec[n][1], rec[n][2], rec[n][3], rec[n][4],
                        rec[n][5], rec[n][6], rec[n][7], rec[n][8], rec[n][9], rec[n][10]));
                    n++;
                end
            end
            $fclose(fd);
        end
    end

    always @(posedge gmii_rxc) begin
        if (rst_q && !rst) begin   // first edge out of reset
            if (rx_valid_i !== 1'b0) value_error("reset_state", "rx_valid_o", 0, rx_valid_i);
            if (rx_done_i !== 1'b0) value_error("reset_state", "rx_done_o", 0, rx_done_i);
            if (rx_drop_cnt_i !== 16'd0) value_error("reset_state", "drop count", 0, rx_drop_cnt_i);
            close_test("reset_state");
        end
        if (!rst && rx_valid_i) begin
            mem[rx_addr_i] = rx_data_i;
            wr_cnt++;
        end
        if (!rst && rx_done_i && !done_q) check_done(test_idx_i);
        if (gap_done_i) finish_test(test_idx_i);
        rst_q  = rst;
        done_q = rx_done_i;
    end

endmodule

// File: testbench/tb_eth_rx.sv
`timescale 1ns/100ps

module tb_eth_rx;
    import eth_rx_pkg::*;

    logic              gmii_rxc = 1'b0;
    logic              rst;
    logic [7:0]        gmii_rxd;
    logic              gmii_rx_dv;
    logic              gmii_rx_er;
    logic [ADDR_W-1:0] base_addr;
    logic              rx_ready;
    logic [7:0]        rx_data;
    logic [ADDR_W-1:0] rx_addr;
    logic              rx_valid;
    logic [ADDR_W-1:0] rx_len;
    frame_status_e     rx_status;
    logic              rx_done;
    logic [15:0]       rx_drop_cnt;
    int                cur_test;
    logic              gap_done;
    int                pass_cnt;
    int                fail_cnt;
    string             names [64];
    int                rec [64][11];   // columns as in the data file, name excluded
    int                n_tests;

    always #5 gmii_rxc = ~gmii_rxc;

    eth_rx_top u_eth_rx_top (
        .gmii_rxc      (gmii_rxc),
        .rst           (rst),
        .gmii_rxd_i    (gmii_rxd),
        .gmii_rx_dv_i  (gmii_rx_dv),
        .gmii_rx_er_i  (gmii_rx_er),
        .rx_addr_i     (base_addr),
        .rx_ready_i    (rx_ready),
        .rx_data_o     (rx_data),
        .rx_addr_o     (rx_addr),
        .rx_valid_o    (rx_valid),
        .rx_len_o      (rx_len),
        .rx_status_o   (rx_status),
        .rx_done_o     (rx_done),
        .rx_drop_cnt_o (rx_drop_cnt)
    );

    rx_checker u_checker (
        .gmii_rxc      (gmii_rxc),
        .rst           (rst),
        .rx_data_i     (rx_data),
        .rx_addr_i     (rx_addr),
        .rx_valid_i    (rx_valid),
        .rx_len_i      (rx_len),
        .rx_status_i   (rx_status),
        .rx_done_i     (rx_done),
        .rx_drop_cnt_i (rx_drop_cnt),
        .test_idx_i    (cur_test),
        .gap_done_i    (gap_done),
        .pass_cnt_o    (pass_cnt),
        .fail_cnt_o    (fail_cnt)
    );

    function automatic logic [7:0] payload_byte(input int s, input int i);
        return 8'(s * 3 + i * 13 + (i >> 5));
    endfunction

    // ethernet fcs, one bit at a time, lsb first
    function automatic logic [31:0] fcs_update(input logic [31:0] c, input logic [7:0] d);
        logic [31:0] r;
        logic        fb;
        r = c;
        for (int b = 0; b < 8; b++) begin
            fb = r[0] ^ d[b];
            r  = {1'b0, r[31:1]} ^ (fb ? 32'hEDB8_8320 : 32'h0);
        end
        return r;
    endfunction

    task automatic acknowledge();
        repeat ($urandom_range(8, 1)) @(posedge gmii_rxc);
        #1 rx_ready = 1'b1;
        while (rx_done) begin
            @(posedge gmii_rxc);
            #1;
        end
        rx_ready = 1'b0;
        repeat (2) @(posedge gmii_rxc);
    endtask

    task automatic send_frame(input int t);
        logic [7:0]  fb [$];
        logic [31:0] fcs;
        logic [7:0]  b;
        fcs = 32'hFFFF_FFFF;
        for (int i = 0; i < rec[t][2] - 4; i++) begin
            b = payload_byte(rec[t][3], i);
            fb.push_back(b);
            fcs = fcs_update(fcs, b);
        end
        fcs = ~fcs;
        for (int k = 0; k < 4; k++) begin
            fb.push_back(fcs[8*k +: 8]);
        end
        if (rec[t][4] >= 0) begin
            fb[rec[t][4]] = fb[rec[t][4]] ^ 8'hFF;   // corrupt after fcs is fixed
        end
        for (int k = 0; k < 8; k++) begin
            @(posedge gmii_rxc);
            #1 gmii_rx_dv = 1'b1;
            gmii_rxd = (k == 7) ? SFD_BYTE : (rec[t][6] != 0 && k == 2) ? 8'h5A : PREAMBLE_BYTE;
        end
        for (int i = 0; i < fb.size(); i++) begin
            @(posedge gmii_rxc);
            #1 gmii_rxd = fb[i];
            gmii_rx_er = (i == rec[t][5]);
        end
        @(posedge gmii_rxc);
        #1 gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        gmii_rxd   = 8'h00;
    endtask

    initial begin
        int    fd;
        int    budget;
        string line;
        rst        = 1'b1;
        gmii_rxd   = 8'h00;
        gmii_rx_dv = 1'b0;
        gmii_rx_er = 1'b0;
        base_addr  = '0;
        rx_ready   = 1'b0;
        cur_test   = 0;
        gap_done   = 1'b0;
        n_tests    = 0;
        budget     = 20;
        void'($urandom(32'h8d53));
        fd = $fopen("testbench/eth_rx_testdata.txt", "r");
        if (fd == 0) begin
            $display("could not open the test data file");
            $display("*** FAILED ***");
            $finish;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 1 && line.getc(0) != "#") begin
                    void'($sscanf(line, "%s %h %d %d %h %d %d %d %d %d %d %d",
                        names[n_tests], rec[n_tests][0], rec[n_tests][1], rec[n_tests][2],
                        rec[n_tests][3], rec[n_tests][4], rec[n_tests][5], rec[n_tests][6],
                        rec[n_tests][7], rec[n_tests][8], rec[n_tests][9], rec[n_tests][10]));
                    budget += rec[n_tests][2] + 43;   // frame, max gap, ack, slack
                    n_tests++;
                end
            end
            $fclose(fd);
            base_addr = rec[0][0];     // writer arms straight out of reset
            fork
                begin
                    #(budget * 20);
                    $display("watchdog expired before all tests finished");
                    $display("*** FAILED ***");
                    $finish;
                end
            join_none
            repeat (10) @(posedge gmii_rxc);
            #1 rst = 1'b0;
            repeat (3) @(posedge gmii_rxc);
            for (int t = 0; t < n_tests; t++) begin
                #1 cur_test = t;
                base_addr = rec[t][0];
                if (rec[t][1] != 0 && rx_done) begin
                    acknowledge();
                end
                send_frame(t);
                repeat ($urandom_range(20, 12)) @(posedge gmii_rxc);
                #1 gap_done = 1'b1;
                @(posedge gmii_rxc);
                #1 gap_done = 1'b0;
            end
            repeat (3) @(posedge gmii_rxc);
            $display("tests: %0d passed, %0d failed", pass_cnt, fail_cnt);
            if (fail_cnt == 0 && pass_cnt == n_tests + 1) begin
                $display("*** PASSED ***");
            end else begin
                $display("*** FAILED ***");
            end
            $finish;
        end
    end

endmodule
